/* src.f */
common/rop_pkg.sv
blend/blend_factor.sv
blend/blend_mult.sv
blend/blend_equation.sv
verilog/rop_blend.sv
sim/rop_blend_properties.sv
sim/rop_blend_tb.sv

/* sim/rop_blend_tb.sv */
// ****************************************
// Testbench for the ROP blend pipeline with a reference model
// Directed and random fragments are checked for value and latency
// ****************************************
`timescale 1ns/1ps

module rop_blend_tb import rop_pkg::*; ();

    logic       clk;
    logic       rst;
    logic       in_valid;
    blend_req_t in_req;
    blend_cfg_t cfg;
    logic       out_valid;
    rgba_t      out_color;

    int seed = 24;
    int cycle = 0;
    int color_errors = 0;
    int latency_errors = 0;
    int other_errors = 0;

    // Expected results in input order together with the cycle of the sampling edge
    rgba_t exp_q[$];
    int    cyc_q[$];
    string name_q[$];

    logic [7:0] alpha_pts [3] = '{8'd0, 8'd128, 8'd255};

    rop_blend uut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_req    (in_req),
        .cfg       (cfg),
        .out_valid (out_valid),
        .out_color (out_color)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fffffff;
        return r % n;
    endfunction

    function automatic rgba_t rand_color();
        rgba_t c;
        c = $random(seed);
        return c;
    endfunction

    // Channel 0 is blue and channel 3 is alpha
    function automatic int chan(input rgba_t c, input int ch);
        case (ch)
            0: return c.b;
            1: return c.g;
            2: return c.r;
            default: return c.a;
        endcase
    endfunction

    function automatic int ref_factor(input blend_func_e f, input int ch,
                                      input rgba_t s, input rgba_t d, input rgba_t k);
        case (f)
            ZERO:                return 0;
            ONE:                 return 255;
            SRC_RGB:             return chan(s, ch);
            ONE_MINUS_SRC_RGB:   return 255 - chan(s, ch);
            SRC_A:               return s.a;
            ONE_MINUS_SRC_A:     return 255 - s.a;
            DST_RGB:             return chan(d, ch);
            ONE_MINUS_DST_RGB:   return 255 - chan(d, ch);
            DST_A:               return d.a;
            ONE_MINUS_DST_A:     return 255 - d.a;
            CONST_RGB:           return chan(k, ch);
            ONE_MINUS_CONST_RGB: return 255 - chan(k, ch);
            CONST_A:             return k.a;
            ONE_MINUS_CONST_A:   return 255 - k.a;
            ALPHA_SAT: begin
                if (ch == 3) return 255;
                return (s.a < 255 - d.a) ? s.a : 255 - d.a;
            end
            default:             return 0;
        endcase
    endfunction

    function automatic rgba_t ref_blend(input blend_req_t req, input blend_cfg_t c);
        logic [3:0][7:0] res;
        int sc, dc, sf, df, st, dt, v;
        blend_mode_e mode;
        for (int ch = 0; ch < 4; ch++) begin
            sc = chan(req.src_color, ch);
            dc = chan(req.dst_color, ch);
            sf = ref_factor((ch == 3) ? c.func_src_a : c.func_src_rgb, ch,
                            req.src_color, req.dst_color, c.const_color);
            df = ref_factor((ch == 3) ? c.func_dst_a : c.func_dst_rgb, ch,
                            req.src_color, req.dst_color, c.const_color);
            st = (sc * sf + 127) / 255;
            dt = (dc * df + 127) / 255;
            mode = (ch == 3) ? c.mode_a : c.mode_rgb;
            case (mode)
                ADD:          v = (st + dt > 255) ? 255 : st + dt;
                SUBTRACT:     v = (st - dt < 0) ? 0 : st - dt;
                REV_SUBTRACT: v = (dt - st < 0) ? 0 : dt - st;
                MIN:          v = (sc < dc) ? sc : dc;
                MAX:          v = (sc > dc) ? sc : dc;
                default:      v = 0;
            endcase
            res[ch] = v[7:0];
        end
        return rgba_t'(res);
    endfunction

    function automatic blend_cfg_t make_cfg(input blend_mode_e m_rgb, input blend_mode_e m_a,
                                            input blend_func_e fsr, input blend_func_e fsa,
                                            input blend_func_e fdr, input blend_func_e fda);
        blend_cfg_t c;
        c.mode_rgb     = m_rgb;
        c.mode_a       = m_a;
        c.func_src_rgb = fsr;
        c.func_src_a   = fsa;
        c.func_dst_rgb = fdr;
        c.func_dst_a   = fda;
        c.const_color  = rand_color();
        return c;
    endfunction

    task automatic check_color(input string name, input rgba_t exp, input rgba_t act);
        if (act !== exp) begin
            $display("** Error [%s] color: expected %h, actual %h", name, exp, act);
            color_errors++;
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error [%s] latency: expected %0d, actual %0d", name, exp, act);
            latency_errors++;
        end
    endtask

    // Leaves in_valid high, so consecutive calls give back-to-back strobes
    task automatic send_frag(input string name, input blend_req_t req, input blend_cfg_t c);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_req   = req;
        cfg      = c;
        exp_q.push_back(ref_blend(req, c));
        cyc_q.push_back(cycle + 1);
        name_q.push_back(name);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    // Outputs settle after the rising edge, so compare on the falling edge
    initial begin
        string tname;
        rgba_t exp_color;
        int    in_cycle;
        forever begin
            @(negedge clk);
            if (out_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Output strobe at cycle %0d with no fragment outstanding", cycle);
                    other_errors++;
                end else begin
                    tname     = name_q.pop_front();
                    exp_color = exp_q.pop_front();
                    in_cycle  = cyc_q.pop_front();
                    check_color(tname, exp_color, out_color);
                    // The strobe seen here is sampled by the next rising edge
                    check_latency(tname, 3, cycle + 1 - in_cycle);
                end
            end
        end
    end

    initial begin
        blend_req_t req;
        blend_cfg_t c;
        int         wait_cycles;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        cfg      = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        req.src_color = 32'h80_c0_40_20;
        req.dst_color = 32'h3f_10_e0_9a;
        send_frag("pass_src", req, make_cfg(ADD, ADD, ONE, ONE, ZERO, ZERO));
        send_frag("pass_dst", req, make_cfg(ADD, ADD, ZERO, ZERO, ONE, ONE));
        idle_cycles(1);

        // Classic alpha blend at the alpha end points and midpoint
        for (int i = 0; i < 3; i++) begin
            req.src_color = {alpha_pts[i], 24'($random(seed))};
            req.dst_color = rand_color();
            c = make_cfg(ADD, ADD, SRC_A, SRC_A, ONE_MINUS_SRC_A, ONE_MINUS_SRC_A);
            send_frag($sformatf("alpha_blend_%0d", alpha_pts[i]), req, c);
        end
        idle_cycles(1);

        req.src_color = 32'hf0f0f0f0;
        req.dst_color = 32'h80808080;
        send_frag("add_saturate", req, make_cfg(ADD, ADD, ONE, ONE, ONE, ONE));
        req.src_color = 32'h20202020;
        req.dst_color = 32'he0e0e0e0;
        send_frag("sub_clamp", req, make_cfg(SUBTRACT, SUBTRACT, ONE, ONE, ONE, ONE));
        req.src_color = 32'he0e0e0e0;
        req.dst_color = 32'h20202020;
        send_frag("rev_sub_clamp", req,
                  make_cfg(REV_SUBTRACT, REV_SUBTRACT, ONE, ONE, ONE, ONE));
        idle_cycles(2);

        for (int i = 0; i < 4; i++) begin
            req.src_color = rand_color();
            req.dst_color = rand_color();
            c = make_cfg((i % 2 == 0) ? MIN : MAX, (i % 2 == 0) ? MAX : MIN,
                         blend_func_e'(rand_below(15)), blend_func_e'(rand_below(15)),
                         blend_func_e'(rand_below(15)), blend_func_e'(rand_below(15)));
            send_frag($sformatf("min_max_%0d", i), req, c);
        end
        idle_cycles(1);

        // Each field walks all fifteen codes from a different start
        for (int k = 0; k < 15; k++) begin
            req.src_color = rand_color();
            req.dst_color = rand_color();
            c = make_cfg(blend_mode_e'(rand_below(5)), blend_mode_e'(rand_below(5)),
                         blend_func_e'(k), blend_func_e'((k + 5) % 15),
                         blend_func_e'((k + 10) % 15), blend_func_e'(14 - k));
            send_frag($sformatf("factor_sweep_%0d", k), req, c);
        end
        idle_cycles(1);

        for (int i = 0; i < 200; i++) begin
            req.src_color = rand_color();
            req.dst_color = rand_color();
            c = make_cfg(blend_mode_e'(rand_below(5)), blend_mode_e'(rand_below(5)),
                         blend_func_e'(rand_below(15)), blend_func_e'(rand_below(15)),
                         blend_func_e'(rand_below(15)), blend_func_e'(rand_below(15)));
            send_frag($sformatf("random_%0d", i), req, c);
            idle_cycles(rand_below(3));
        end
        idle_cycles(1);

        wait_cycles = 0;
        while (exp_q.size() > 0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("Timeout: %0d fragments never came out of the pipeline", exp_q.size());
            other_errors++;
        end
        repeat (4) @(posedge clk);

        $display("Errors: color %0d, latency %0d, other %0d",
                 color_errors, latency_errors, other_errors);
        if (color_errors + latency_errors + other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* sim/rop_blend_properties.sv */
// ****************************************
// Assertions on reset state, latency and output validity
// Bound to the rop_blend top level
// ****************************************
`timescale 1ns/1ps

module rop_blend_properties import rop_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  in_valid,
    input logic  out_valid,
    input rgba_t out_color
);

    // Reset clears the strobe by the next edge and holds it low
    a_reset_low: assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high during or right after reset");

    a_latency: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##3 out_valid)
        else $error("out_valid did not follow in_valid after 3 cycles");

    a_no_spurious: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without a matching in_valid 3 cycles earlier");

    a_known: assert property (@(posedge clk) out_valid |-> !$isunknown(out_color))
        else $error("out_color has unknown bits while out_valid is high");

endmodule

bind rop_blend rop_blend_properties u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .out_color (out_color)
);

/* verilog/rop_blend.sv */
// ****************************************
// ROP color blend top, three registered stages
// Latency is 3 cycles from in_valid to out_valid
// ****************************************
`timescale 1ns/1ps

module rop_blend import rop_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       in_valid,
    input  blend_req_t in_req,
    input  blend_cfg_t cfg,
    output logic       out_valid,
    output rgba_t      out_color
);

    // Factor stage to multiply stage
    logic         fac_valid;
    rgba_t        fac_src_factor;
    rgba_t        fac_dst_factor;
    blend_req_t   fac_colors;
    blend_modes_t fac_modes;

    // Multiply stage to equation stage
    logic         mul_valid;
    rgba_t        mul_src_term;
    rgba_t        mul_dst_term;
    blend_req_t   mul_colors;
    blend_modes_t mul_modes;

    blend_factor u_factor (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_req     (in_req),
        .cfg        (cfg),
        .out_valid  (fac_valid),
        .src_factor (fac_src_factor),
        .dst_factor (fac_dst_factor),
        .colors     (fac_colors),
        .modes      (fac_modes)
    );

    blend_mult u_mult (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (fac_valid),
        .src_factor (fac_src_factor),
        .dst_factor (fac_dst_factor),
        .in_colors  (fac_colors),
        .in_modes   (fac_modes),
        .out_valid  (mul_valid),
        .src_term   (mul_src_term),
        .dst_term   (mul_dst_term),
        .out_colors (mul_colors),
        .out_modes  (mul_modes)
    );

    blend_equation u_equation (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (mul_valid),
        .src_term  (mul_src_term),
        .dst_term  (mul_dst_term),
        .in_colors (mul_colors),
        .in_modes  (mul_modes),
        .out_valid (out_valid),
        .out_color (out_color)
    );

endmodule

/* blend/blend_equation.sv */
// ****************************************
// Blend stage 3, applies the equation mode with saturation
// ****************************************
`timescale 1ns/1ps

module blend_equation import rop_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  rgba_t        src_term,
    input  rgba_t        dst_term,
    input  blend_req_t   in_colors,
    input  blend_modes_t in_modes,
    output logic         out_valid,
    output rgba_t        out_color
);

    function automatic logic [7:0] blend_chan(
        input blend_mode_e mode,
        input logic [7:0]  s_term,
        input logic [7:0]  d_term,
        input logic [7:0]  s_col,
        input logic [7:0]  d_col
    );
        logic [8:0] sum;
        logic [7:0] res;
        sum = {1'b0, s_term} + {1'b0, d_term};
        case (mode)
            ADD: begin
                // Carry out means the sum overflowed one
                res = sum[8] ? 8'hff : sum[7:0];
            end
            SUBTRACT: begin
                res = (s_term > d_term) ? s_term - d_term : 8'h00;
            end
            REV_SUBTRACT: begin
                res = (d_term > s_term) ? d_term - s_term : 8'h00;
            end
            MIN: begin
                res = (s_col < d_col) ? s_col : d_col;
            end
            MAX: begin
                res = (s_col > d_col) ? s_col : d_col;
            end
            default: begin
                res = 8'h00;
            end
        endcase
        return res;
    endfunction

    rgba_t color_d;

    always_comb begin
        color_d.r = blend_chan(in_modes.mode_rgb, src_term.r, dst_term.r,
                               in_colors.src_color.r, in_colors.dst_color.r);
        color_d.g = blend_chan(in_modes.mode_rgb, src_term.g, dst_term.g,
                               in_colors.src_color.g, in_colors.dst_color.g);
        color_d.b = blend_chan(in_modes.mode_rgb, src_term.b, dst_term.b,
                               in_colors.src_color.b, in_colors.dst_color.b);
        // Alpha has its own equation mode
        color_d.a = blend_chan(in_modes.mode_a, src_term.a, dst_term.a,
                               in_colors.src_color.a, in_colors.dst_color.a);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_color <= color_d;
        end
    end

endmodule

/* blend/blend_mult.sv */
// ****************************************
// Second blend stage that weights each color channel by its factor
// ****************************************
`timescale 1ns/1ps

module blend_mult import rop_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  rgba_t        src_factor,
    input  rgba_t        dst_factor,
    input  blend_req_t   in_colors,
    input  blend_modes_t in_modes,
    output logic         out_valid,
    output rgba_t        src_term,
    output rgba_t        dst_term,
    output blend_req_t   out_colors,
    output blend_modes_t out_modes
);

    // Rounded c*f/255 without a divider. With t = c*f + 128 the
    // value (t + (t >> 8)) >> 8 is exact for all 8-bit operands
    function automatic logic [7:0] norm_mul(
        input logic [7:0] c,
        input logic [7:0] f
    );
        logic [16:0] t;
        logic [16:0] q;
        t = c * f + 17'd128;
        q = (t + (t >> 8)) >> 8;
        return q[7:0];
    endfunction

    rgba_t src_term_d;
    rgba_t dst_term_d;

    always_comb begin
        src_term_d.a = norm_mul(in_colors.src_color.a, src_factor.a);
        src_term_d.r = norm_mul(in_colors.src_color.r, src_factor.r);
        src_term_d.g = norm_mul(in_colors.src_color.g, src_factor.g);
        src_term_d.b = norm_mul(in_colors.src_color.b, src_factor.b);
        dst_term_d.a = norm_mul(in_colors.dst_color.a, dst_factor.a);
        dst_term_d.r = norm_mul(in_colors.dst_color.r, dst_factor.r);
        dst_term_d.g = norm_mul(in_colors.dst_color.g, dst_factor.g);
        dst_term_d.b = norm_mul(in_colors.dst_color.b, dst_factor.b);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // MIN and MAX need the unweighted colors, so they ride along
    always_ff @(posedge clk) begin
        if (in_valid) begin
            src_term   <= src_term_d;
            dst_term   <= dst_term_d;
            out_colors <= in_colors;
            out_modes  <= in_modes;
        end
    end

endmodule

/* blend/blend_factor.sv */
// ****************************************
// Blend stage 1, selects source and destination factors per channel
// Registers factors together with colors and equation modes
// ****************************************
`timescale 1ns/1ps

module blend_factor import rop_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  blend_req_t   in_req,
    input  blend_cfg_t   cfg,
    output logic         out_valid,
    output rgba_t        src_factor,
    output rgba_t        dst_factor,
    output blend_req_t   colors,
    output blend_modes_t modes
);

    // Channel index follows the packed layout: 0 is blue, 3 is alpha
    function automatic logic [7:0] factor_sel(
        input blend_func_e func,
        input logic [1:0]  ch,
        input rgba_t       src,
        input rgba_t       dst,
        input rgba_t       cst
    );
        logic [3:0][7:0] s;
        logic [3:0][7:0] d;
        logic [3:0][7:0] c;
        logic [7:0]      inv_dst_a;
        logic [7:0]      res;
        s = src;
        d = dst;
        c = cst;
        inv_dst_a = 8'hff - dst.a;
        case (func)
            ZERO:                res = 8'h00;
            ONE:                 res = 8'hff;
            SRC_RGB:             res = s[ch];
            ONE_MINUS_SRC_RGB:   res = 8'hff - s[ch];
            SRC_A:               res = src.a;
            ONE_MINUS_SRC_A:     res = 8'hff - src.a;
            DST_RGB:             res = d[ch];
            ONE_MINUS_DST_RGB:   res = 8'hff - d[ch];
            DST_A:               res = dst.a;
            ONE_MINUS_DST_A:     res = inv_dst_a;
            CONST_RGB:           res = c[ch];
            ONE_MINUS_CONST_RGB: res = 8'hff - c[ch];
            CONST_A:             res = cst.a;
            ONE_MINUS_CONST_A:   res = 8'hff - cst.a;
            ALPHA_SAT: begin
                // Alpha itself saturates to one
                if (ch == 2'd3) begin
                    res = 8'hff;
                end else begin
                    res = (src.a < inv_dst_a) ? src.a : inv_dst_a;
                end
            end
            default:             res = 8'h00;
        endcase
        return res;
    endfunction

    rgba_t src_factor_d;
    rgba_t dst_factor_d;

    always_comb begin
        src_factor_d.b = factor_sel(cfg.func_src_rgb, 2'd0, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        src_factor_d.g = factor_sel(cfg.func_src_rgb, 2'd1, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        src_factor_d.r = factor_sel(cfg.func_src_rgb, 2'd2, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        src_factor_d.a = factor_sel(cfg.func_src_a, 2'd3, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        dst_factor_d.b = factor_sel(cfg.func_dst_rgb, 2'd0, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        dst_factor_d.g = factor_sel(cfg.func_dst_rgb, 2'd1, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        dst_factor_d.r = factor_sel(cfg.func_dst_rgb, 2'd2, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
        dst_factor_d.a = factor_sel(cfg.func_dst_a, 2'd3, in_req.src_color,
                                    in_req.dst_color, cfg.const_color);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            src_factor     <= src_factor_d;
            dst_factor     <= dst_factor_d;
            colors         <= in_req;
            modes.mode_rgb <= cfg.mode_rgb;
            modes.mode_a   <= cfg.mode_a;
        end
    end

endmodule

/* common/rop_pkg.sv */
// ****************************************
// Shared color, blend function and equation types for the ROP blend pipeline
// Imported by every blend stage and the top level
// ****************************************
package rop_pkg;

    // 8-bit RGBA color, alpha in the top byte
    typedef struct packed {
        logic [7:0] a;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgba_t;

    // Blend factor functions, code 15 is unused and selects zero
    typedef enum logic [3:0] {
        ZERO                = 4'd0,
        ONE                 = 4'd1,
        SRC_RGB             = 4'd2,
        ONE_MINUS_SRC_RGB   = 4'd3,
        SRC_A               = 4'd4,
        ONE_MINUS_SRC_A     = 4'd5,
        DST_RGB             = 4'd6,
        ONE_MINUS_DST_RGB   = 4'd7,
        DST_A               = 4'd8,
        ONE_MINUS_DST_A     = 4'd9,
        CONST_RGB           = 4'd10,
        ONE_MINUS_CONST_RGB = 4'd11,
        CONST_A             = 4'd12,
        ONE_MINUS_CONST_A   = 4'd13,
        ALPHA_SAT           = 4'd14
    } blend_func_e;

    // Blend equation modes
    typedef enum logic [2:0] {
        ADD          = 3'd0,
        SUBTRACT     = 3'd1,
        REV_SUBTRACT = 3'd2,
        MIN          = 3'd3,
        MAX          = 3'd4
    } blend_mode_e;

    typedef struct packed {
        blend_mode_e mode_rgb;
        blend_mode_e mode_a;
        blend_func_e func_src_rgb;
        blend_func_e func_src_a;
        blend_func_e func_dst_rgb;
        blend_func_e func_dst_a;
        rgba_t       const_color;
    } blend_cfg_t;

    typedef struct packed {
        rgba_t src_color;
        rgba_t dst_color;
    } blend_req_t;

    // Equation modes carried down the pipe after factor selection
    typedef struct packed {
        blend_mode_e mode_rgb;
        blend_mode_e mode_a;
    } blend_modes_t;

endpackage
